// File: include/stream_settings.svh
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// operand and result width
`define DATA_W 16

// command tag width, tags wrap 0..15
`define TAG_W 4

// entries per fifo, power of two
`define FIFO_DEPTH 8

// fill level width, counts 0..FIFO_DEPTH
`define LEVEL_W ($clog2(`FIFO_DEPTH) + 1)

`endif

// File: hdl/stream_pkg.sv
`include "stream_settings.svh"

package stream_pkg;

    typedef enum logic [2:0] {
        op_add = 3'd0,  // a + b
        op_sub = 3'd1,  // a - b
        op_and = 3'd2,
        op_xor = 3'd3,
        op_acc = 3'd4,  // acc += a
        op_clr = 3'd5   // acc = 0
    } op_e;

    // command word, 39 bits
    typedef struct packed {
        op_e               op;
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
    } cmd_t;

    // result word, 21 bits
    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] value;
        logic               zero;  // value == 0
    } result_t;

    // occupancy of one execute stage
    typedef enum logic {
        exec_idle   = 1'b0,
        exec_loaded = 1'b1
    } exec_state_e;

endpackage : stream_pkg

// File: hdl/sync_fifo.sv
`timescale 1ns/1ns
`include "stream_settings.svh"

module sync_fifo import stream_pkg::*; #(
    parameter int DEPTH = `FIFO_DEPTH,
    parameter int WIDTH = $bits(cmd_t),
    localparam int AW   = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             reset_n,

    // write side
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_ready,

    // read side
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready,

    output logic [AW:0]      level
);
    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      head;  // read pointer, msb is the wrap bit
    logic [AW:0]      tail;  // write pointer
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    always_comb begin : ptr_compare
        if ((head ^ tail) == {1'b1, {AW{1'b0}}}) begin
            full  = 1'b1;  // same slot, other lap
            empty = 1'b0;
        end
        else if (head == tail) begin
            full  = 1'b0;
            empty = 1'b1;
        end
        else begin
            full  = 1'b0;
            empty = 1'b0;
        end
    end : ptr_compare

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign wr_en     = in_valid && !full;
    assign rd_en     = out_ready && !empty;

    // head entry stays put until it is read
    assign out_data = mem[head[AW-1:0]];

    // wraps correctly thanks to the extra bit
    assign level = tail - head;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            head <= '0;
            tail <= '0;
        end
        else begin
            if (wr_en) begin
                tail <= tail + 1'b1;
            end
            if (rd_en) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[tail[AW-1:0]] <= in_data;
        end
    end

endmodule : sync_fifo

// File: hdl/cmd_exec.sv
`timescale 1ns/1ns
`include "stream_settings.svh"

module cmd_exec import stream_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,

    // commands from the input fifo
    input  logic    cmd_valid,
    input  cmd_t    cmd,
    output logic    cmd_ready,

    // results toward the output fifo
    output logic    res_valid,
    output result_t res,
    input  logic    res_ready
);
    // occupancy
    exec_state_e        s1_state;
    exec_state_e        s2_state;

    // stage 1 payload
    op_e                s1_op;
    logic [`TAG_W-1:0]  s1_tag;
    logic [`DATA_W-1:0] s1_val;   // raw result, or operand a for op_acc

    // stage 2 payload
    result_t            s2_res;

    logic [`DATA_W-1:0] acc;
    logic [`DATA_W-1:0] acc_next;
    logic [`DATA_W-1:0] raw_val;
    logic [`DATA_W-1:0] final_val;

    logic               advance;
    logic               accept;
    logic               s1_move;

    // whole pipe shifts when stage 2 is empty or leaving
    assign advance   = (s2_state == exec_idle) || res_ready;
    assign cmd_ready = advance;
    assign accept    = cmd_valid && advance;
    assign s1_move   = advance && (s1_state == exec_loaded);

    assign res_valid = (s2_state == exec_loaded);
    assign res       = s2_res;

    // stage 1 arithmetic
    always_comb begin : stage1_alu
        case (cmd.op)
            op_add:  raw_val = cmd.a + cmd.b;
            op_sub:  raw_val = cmd.a - cmd.b;
            op_and:  raw_val = cmd.a & cmd.b;
            op_xor:  raw_val = cmd.a ^ cmd.b;
            op_acc:  raw_val = cmd.a;  // summed in stage 2
            default: raw_val = '0;
        endcase
    end : stage1_alu

    // stage 2 accumulator ops, in command order
    always_comb begin : stage2_acc
        case (s1_op)
            op_acc: begin
                acc_next  = acc + s1_val;
                final_val = acc_next;
            end
            op_clr: begin
                acc_next  = '0;
                final_val = '0;
            end
            default: begin
                acc_next  = acc;
                final_val = s1_val;
            end
        endcase
    end : stage2_acc

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_state <= exec_idle;
            s2_state <= exec_idle;
            acc      <= '0;
        end
        else if (advance) begin
            s1_state <= accept ? exec_loaded : exec_idle;
            s2_state <= s1_state;
            if (s1_state == exec_loaded) begin
                acc <= acc_next;
            end
        end
    end

    // payload, qualified by the state bits above
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_op  <= cmd.op;
            s1_tag <= cmd.tag;
            s1_val <= raw_val;
        end
        if (s1_move) begin
            s2_res.tag   <= s1_tag;
            s2_res.value <= final_val;
            s2_res.zero  <= (final_val == '0);
        end
    end

endmodule : cmd_exec

// File: hdl/stream_proc_top.sv
`timescale 1ns/1ns
`include "stream_settings.svh"

module stream_proc_top import stream_pkg::*; (
    input  logic                clk,
    input  logic                reset_n,

    input  logic                cmd_valid,
    input  cmd_t                cmd,
    output logic                cmd_ready,

    output logic                result_valid,
    output result_t             result,
    input  logic                result_ready,

    output logic [`LEVEL_W-1:0] in_level,
    output logic [`LEVEL_W-1:0] out_level
);
    // in_fifo -> exec
    logic    q_cmd_valid;
    cmd_t    q_cmd;
    logic    q_cmd_ready;

    // exec -> out_fifo
    logic    res_valid;
    result_t res;
    logic    res_ready;

    sync_fifo #(.DEPTH(`FIFO_DEPTH), .WIDTH($bits(cmd_t))) in_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (cmd_valid),
        .in_data   (cmd),
        .in_ready  (cmd_ready),
        .out_valid (q_cmd_valid),
        .out_data  (q_cmd),
        .out_ready (q_cmd_ready),
        .level     (in_level)
    );

    cmd_exec exec (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_valid (q_cmd_valid),
        .cmd       (q_cmd),
        .cmd_ready (q_cmd_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    sync_fifo #(.DEPTH(`FIFO_DEPTH), .WIDTH($bits(result_t))) out_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (res_valid),
        .in_data   (res),
        .in_ready  (res_ready),
        .out_valid (result_valid),
        .out_data  (result),
        .out_ready (result_ready),
        .level     (out_level)
    );

endmodule : stream_proc_top

// File: tb/stream_checker.sv
`timescale 1ns/1ns
`include "stream_settings.svh"

module stream_checker import stream_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               cmd_valid,
    input  cmd_t               cmd,
    input  logic               cmd_ready,
    input  logic [`DATA_W-1:0] exp_value,  // value from the pattern file
    input  logic               result_valid,
    input  result_t            result,
    input  logic               result_ready,
    output int                 errors,
    output int                 checked,
    output int                 pending
);
    logic [`TAG_W-1:0]  tag_q[$];
    logic [`DATA_W-1:0] val_q[$];
    logic [`DATA_W-1:0] acc_model;

    // reference model of one command, straight from the opcode rules
    function automatic logic [`DATA_W-1:0] predict_value(input cmd_t c,
                                                         input logic [`DATA_W-1:0] acc);
        case (c.op)
            op_add:  return c.a + c.b;
            op_sub:  return c.a - c.b;
            op_and:  return c.a & c.b;
            op_xor:  return c.a ^ c.b;
            op_acc:  return acc + c.a;
            default: return '0;
        endcase
    endfunction

    always @(posedge clk or negedge reset_n) begin
        logic [`DATA_W-1:0] want;
        logic [`TAG_W-1:0]  want_tag;
        if (!reset_n) begin
            tag_q.delete();
            val_q.delete();
            acc_model = '0;
            errors    = 0;
            checked   = 0;
            pending   = 0;
        end
        else begin
            if (cmd_valid && cmd_ready) begin
                want = predict_value(cmd, acc_model);
                if (cmd.op == op_acc || cmd.op == op_clr) begin
                    acc_model = want;
                end
                if (want !== exp_value) begin
                    $display("MISMATCH pattern_value tag %h: expected %h got %h",
                             cmd.tag, want, exp_value);
                    errors++;
                end
                tag_q.push_back(cmd.tag);
                val_q.push_back(want);
            end
            if (result_valid && result_ready) begin
                if (tag_q.size() == 0) begin
                    $display("result came out with no command outstanding");
                    errors++;
                end
                else begin
                    want_tag = tag_q.pop_front();
                    want     = val_q.pop_front();
                    checked++;
                    if (result.tag !== want_tag) begin
                        $display("MISMATCH result.tag: expected %h got %h",
                                 want_tag, result.tag);
                        errors++;
                    end
                    if (result.value !== want) begin
                        $display("MISMATCH result.value: expected %h got %h",
                                 want, result.value);
                        errors++;
                    end
                    if (result.zero !== (want == '0)) begin
                        $display("MISMATCH result.zero: expected %h got %h",
                                 (want == '0), result.zero);
                        errors++;
                    end
                end
            end
            pending = tag_q.size();
        end
    end

endmodule : stream_checker

// File: tb/tb_stream_proc.sv
`timescale 1ns/1ns
`include "stream_settings.svh"

module tb_stream_proc import stream_pkg::*; ;
    logic                clk;
    logic                reset_n;
    logic                cmd_valid;
    cmd_t                cmd;
    logic                cmd_ready;
    logic                result_valid;
    result_t             result;
    logic                result_ready;
    logic [`LEVEL_W-1:0] in_level;
    logic [`LEVEL_W-1:0] out_level;
    logic [`DATA_W-1:0]  exp_value;

    int chk_errors;
    int chk_checked;
    int chk_pending;

    // pattern table
    int                 p_test[$];
    int                 p_op[$];
    logic [`DATA_W-1:0] p_a[$];
    logic [`DATA_W-1:0] p_b[$];
    logic [`DATA_W-1:0] p_exp[$];

    integer            seed = 70771;
    int                ready_mode = 0;  // 0 low, 1 high, 2 random
    logic [`TAG_W-1:0] tag_ctr = '0;
    int                tb_errors = 0;
    int                cycles = 0;
    int                limit = 1000000;
    int                tests_run = 0;
    int                tests_failed = 0;

    stream_proc_top dut (
        .clk(clk), .reset_n(reset_n),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
        .result_valid(result_valid), .result(result), .result_ready(result_ready),
        .in_level(in_level), .out_level(out_level)
    );

    stream_checker chk (
        .clk(clk), .reset_n(reset_n),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready), .exp_value(exp_value),
        .result_valid(result_valid), .result(result), .result_ready(result_ready),
        .errors(chk_errors), .checked(chk_checked), .pending(chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run exceeded %0d cycles without finishing", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // output side handshake
    initial begin
        forever begin
            @(posedge clk);
            #1;
            case (ready_mode)
                0:       result_ready = 1'b0;
                1:       result_ready = 1'b1;
                default: result_ready = ({$random(seed)} % 4) != 0;
            endcase
        end
    end

    task automatic load_patterns();
        int    fd;
        int    n;
        int    t, op;
        logic [`DATA_W-1:0] a, b, e;
        string line;
        fd = $fopen("tb/stream_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/stream_patterns.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", t, op, a, b, e);
                if (n == 5) begin
                    p_test.push_back(t);
                    p_op.push_back(op);
                    p_a.push_back(a);
                    p_b.push_back(b);
                    p_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // one command, held until accepted
    task automatic send_cmd(input int idx, input bit gaps);
        bit ok;
        int n;
        if (gaps) begin
            n = {$random(seed)} % 3;
            repeat (n) begin
                cmd_valid = 1'b0;
                @(posedge clk);
                #1;
            end
        end
        cmd_valid = 1'b1;
        cmd.op    = op_e'(p_op[idx][2:0]);
        cmd.tag   = tag_ctr;
        cmd.a     = p_a[idx];
        cmd.b     = p_b[idx];
        exp_value = p_exp[idx];
        do begin
            ok = cmd_ready;  // stable until the next edge
            @(posedge clk);
            #1;
        end while (!ok);
        cmd_valid = 1'b0;
        tag_ctr++;
    endtask

    task automatic wait_drained();
        while (chk_pending != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expect_value(input string name, input logic [31:0] want,
                                input logic [31:0] got);
        if (want !== got) begin
            $display("MISMATCH %s: expected %h got %h", name, want, got);
            tb_errors++;
        end
    endtask

    task automatic run_test(input int t, input string name);
        int errs_before;
        int sent;
        int lat;
        errs_before = chk_errors + tb_errors;
        sent = 0;
        ready_mode = (t == 5) ? 0 : ((t == 6) ? 1 : 2);
        for (int i = 0; i < p_test.size(); i++) begin
            if (p_test[i] == t) begin
                if (t == 5 && !cmd_ready) begin
                    break;  // input side filled up early
                end
                send_cmd(i, t < 5);
                sent++;
                if (t == 6) begin
                    lat = 1;  // counts the edge where valid is first sampled
                    while (!result_valid && lat < 20) begin
                        @(posedge clk);
                        #1;
                        lat++;
                    end
                    expect_value("latency", 4, lat);
                end
            end
        end
        if (t == 5) begin
            expect_value("accepted", 18, sent);
            repeat (6) begin
                @(posedge clk);
                #1;
            end
            expect_value("cmd_ready", 0, cmd_ready);
            expect_value("out_level", 8, out_level);
            expect_value("in_level", 8, in_level);
            ready_mode = 1;
        end
        wait_drained();
        expect_value("in_level", 0, in_level);
        expect_value("out_level", 0, out_level);
        tests_run++;
        if (chk_errors + tb_errors == errs_before) begin
            $display("test %0d %s: pass (%0d commands)", t, name, sent);
        end
        else begin
            tests_failed++;
            $display("test %0d %s: FAIL", t, name);
        end
    endtask

    initial begin
        reset_n      = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        result_ready = 1'b0;
        exp_value    = '0;
        load_patterns();
        limit = p_test.size() * 40 + 200;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // reset state
        expect_value("cmd_ready", 1, cmd_ready);
        expect_value("result_valid", 0, result_valid);
        expect_value("in_level", 0, in_level);
        expect_value("out_level", 0, out_level);
        tests_run++;
        if (tb_errors == 0) begin
            $display("test 1 reset state: pass");
        end
        else begin
            tests_failed++;
            $display("test 1 reset state: FAIL");
        end

        run_test(2, "operators");
        run_test(3, "accumulator");
        run_test(4, "ordering and tags");
        run_test(5, "back-pressure and capacity");
        run_test(6, "idle latency");

        $display("tests %0d, failed %0d, results checked %0d, errors %0d",
                 tests_run, tests_failed, chk_checked, chk_errors + tb_errors);
        if (tests_failed == 0 && chk_errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end
        else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_stream_proc

// File: tb/stream_patterns.txt
# columns: test op a b expected, all hex
# op codes: 0 add, 1 sub, 2 and, 3 xor, 4 acc, 5 clr
2 0 1234 4321 5555
2 0 ffff 0001 0000
2 0 8000 8000 0000
2 1 0005 0007 fffe
2 1 1234 1234 0000
2 2 f0f0 3c3c 3030
2 2 00ff ff00 0000
2 3 aaaa 5555 ffff
2 3 1234 1234 0000
3 5 0000 0000 0000
3 4 0010 0000 0010
3 4 0020 0000 0030
3 4 fff0 0000 0020
3 5 0000 0000 0000
3 4 0005 0000 0005
3 4 0003 0000 0008
4 0 0100 0023 0123
4 1 0100 0001 00ff
4 2 ffff 1234 1234
4 3 00ff 0f0f 0ff0
4 4 0002 0000 000a
4 0 7fff 0001 8000
4 1 0000 0001 ffff
4 3 5a5a 5a5a 0000
4 2 1111 2222 0000
4 4 fff6 0000 0000
5 0 0001 0100 0101
5 0 0002 0100 0102
5 0 0003 0100 0103
5 0 0004 0100 0104
5 0 0005 0100 0105
5 0 0006 0100 0106
5 0 0007 0100 0107
5 0 0008 0100 0108
5 0 0009 0100 0109
5 0 000a 0100 010a
5 0 000b 0100 010b
5 0 000c 0100 010c
5 0 000d 0100 010d
5 0 000e 0100 010e
5 0 000f 0100 010f
5 0 0010 0100 0110
5 0 0011 0100 0111
5 0 0012 0100 0112
6 0 0003 0004 0007

// File: all.f
+incdir+include
hdl/stream_pkg.sv
hdl/sync_fifo.sv
hdl/cmd_exec.sv
hdl/stream_proc_top.sv
tb/stream_checker.sv
tb/tb_stream_proc.sv
